//--- verilog/rv_core_pkg.sv
// shared widths, opcodes, control codes and instruction formats, imported by every core unit
`default_nettype none

package rv_core_pkg;

	localparam int unsigned xlen      = 32;
	localparam int unsigned reg_idx_w = 5;
	localparam int unsigned n_regs    = 32;

	// major opcodes
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_reg    = 7'b0110011;

	localparam logic [2:0] f3_add = 3'b000;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_or  = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;
	localparam logic [2:0] f3_beq = 3'b000;
	localparam logic [2:0] f3_bne = 3'b001;

	// funct7 bit 5 turns add into sub
	localparam int unsigned f7_sub_bit = 5;

	localparam int unsigned alu_op_w = 3;
	localparam logic [alu_op_w-1:0] alu_add = 3'd0;
	localparam logic [alu_op_w-1:0] alu_sub = 3'd1;
	localparam logic [alu_op_w-1:0] alu_and = 3'd2;
	localparam logic [alu_op_w-1:0] alu_or  = 3'd3;
	localparam logic [alu_op_w-1:0] alu_xor = 3'd4;

	localparam int unsigned wb_sel_w = 2;
	localparam logic [wb_sel_w-1:0] wb_alu  = 2'd0;
	localparam logic [wb_sel_w-1:0] wb_mem  = 2'd1;
	localparam logic [wb_sel_w-1:0] wb_link = 2'd2;

	localparam logic [xlen-1:0] pc_reset = '0;

	// one instruction word, six ways to read it
	typedef union packed {
		struct packed {
			logic [6:0]           funct7;
			logic [reg_idx_w-1:0] rs2;
			logic [reg_idx_w-1:0] rs1;
			logic [2:0]           funct3;
			logic [reg_idx_w-1:0] rd;
			logic [6:0]           opcode;
		} r;
		struct packed {
			logic [11:0]          imm_11_0;
			logic [reg_idx_w-1:0] rs1;
			logic [2:0]           funct3;
			logic [reg_idx_w-1:0] rd;
			logic [6:0]           opcode;
		} i;
		struct packed {
			logic [6:0]           imm_11_5;
			logic [reg_idx_w-1:0] rs2;
			logic [reg_idx_w-1:0] rs1;
			logic [2:0]           funct3;
			logic [4:0]           imm_4_0;
			logic [6:0]           opcode;
		} s;
		struct packed {
			logic                 imm_12;
			logic [5:0]           imm_10_5;
			logic [reg_idx_w-1:0] rs2;
			logic [reg_idx_w-1:0] rs1;
			logic [2:0]           funct3;
			logic [3:0]           imm_4_1;
			logic                 imm_11;
			logic [6:0]           opcode;
		} b;
		struct packed {
			logic [19:0]          imm_31_12;
			logic [reg_idx_w-1:0] rd;
			logic [6:0]           opcode;
		} u;
		struct packed {
			logic                 imm_20;
			logic [9:0]           imm_10_1;
			logic                 imm_11;
			logic [7:0]           imm_19_12;
			logic [reg_idx_w-1:0] rd;
			logic [6:0]           opcode;
		} j;
	} inst_u;

endpackage

`default_nettype wire

//--- verilog/pc_unit.sv
// program counter register with next-PC selection, instantiated once in the core top
`timescale 1ns/1ns
`default_nettype none

module pc_unit (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          redirect,
	input  logic [rv_core_pkg::xlen-1:0]  redirect_target,
	output logic [rv_core_pkg::xlen-1:0]  pc
);

	import rv_core_pkg::*;

	logic [xlen-1:0] pc_next;

	// taken branch or jal wins over sequential fetch
	assign pc_next = redirect ? redirect_target : pc + xlen'(4);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= pc_reset;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

//--- verilog/inst_decoder.sv
// instruction decoder, forms immediates and control for the kept RV32I subset
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
	input  rv_core_pkg::inst_u                   inst,
	input  logic                                 rst_n,
	output logic [rv_core_pkg::reg_idx_w-1:0]    rs1_idx,
	output logic [rv_core_pkg::reg_idx_w-1:0]    rs2_idx,
	output logic [rv_core_pkg::reg_idx_w-1:0]    rd_idx,
	output logic                                 rd_we,
	output logic [rv_core_pkg::xlen-1:0]         imm,
	output logic [rv_core_pkg::alu_op_w-1:0]     alu_op,
	output logic                                 alu_src_imm,
	output logic [rv_core_pkg::wb_sel_w-1:0]     wb_sel,
	output logic                                 is_branch,
	output logic                                 branch_ne,
	output logic                                 is_jal,
	output logic                                 mem_we
);

	import rv_core_pkg::*;

	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] imm_j;
	logic            reg_write;
	logic            mem_write;

	// sign-extended immediates, one per format
	assign imm_i = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
	assign imm_s = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
	assign imm_b = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
		inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
	assign imm_u = {inst.u.imm_31_12, 12'b0};
	assign imm_j = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
		inst.j.imm_11, inst.j.imm_10_1, 1'b0};

	always_comb begin
		rs1_idx     = inst.r.rs1;
		rs2_idx     = inst.r.rs2;
		rd_idx      = inst.r.rd;
		imm         = '0;
		alu_op      = alu_add;
		alu_src_imm = 1'b0;
		wb_sel      = wb_alu;
		is_branch   = 1'b0;
		branch_ne   = 1'b0;
		is_jal      = 1'b0;
		reg_write   = 1'b0;
		mem_write   = 1'b0;
		case (inst.r.opcode)
			op_lui: begin
				// x0 + imm through the adder
				rs1_idx     = '0;
				imm         = imm_u;
				alu_src_imm = 1'b1;
				reg_write   = 1'b1;
			end
			op_imm: begin
				imm         = imm_i;
				alu_src_imm = 1'b1;
				reg_write   = 1'b1;
				case (inst.i.funct3)
					f3_add:  alu_op = alu_add;
					f3_xor:  alu_op = alu_xor;
					f3_or:   alu_op = alu_or;
					f3_and:  alu_op = alu_and;
					default: reg_write = 1'b0;
				endcase
			end
			op_reg: begin
				reg_write = 1'b1;
				case (inst.r.funct3)
					f3_add:  alu_op = inst.r.funct7[f7_sub_bit] ? alu_sub : alu_add;
					f3_xor:  alu_op = alu_xor;
					f3_or:   alu_op = alu_or;
					f3_and:  alu_op = alu_and;
					default: reg_write = 1'b0;
				endcase
			end
			op_branch: begin
				imm       = imm_b;
				is_branch = (inst.b.funct3 == f3_beq) || (inst.b.funct3 == f3_bne);
				branch_ne = (inst.b.funct3 == f3_bne);
			end
			op_jal: begin
				imm       = imm_j;
				is_jal    = 1'b1;
				wb_sel    = wb_link;
				reg_write = 1'b1;
			end
			op_load: begin
				imm         = imm_i;
				alu_src_imm = 1'b1;
				wb_sel      = wb_mem;
				reg_write   = 1'b1;
			end
			op_store: begin
				imm         = imm_s;
				alu_src_imm = 1'b1;
				mem_write   = 1'b1;
			end
			default: begin
			end
		endcase
	end

	// no state may change while the core is held in reset
	assign rd_we  = reg_write & rst_n;
	assign mem_we = mem_write & rst_n;

endmodule

`default_nettype wire

//--- verilog/gpr_file.sv
// general-purpose register file, two combinational reads and one clocked write
`timescale 1ns/1ns
`default_nettype none

module gpr_file (
	input  logic                               clk,
	input  logic [rv_core_pkg::reg_idx_w-1:0]  rs1_idx,
	input  logic [rv_core_pkg::reg_idx_w-1:0]  rs2_idx,
	input  logic [rv_core_pkg::reg_idx_w-1:0]  rd_idx,
	input  logic                               rd_we,
	input  logic [rv_core_pkg::xlen-1:0]       wb_data,
	output logic [rv_core_pkg::xlen-1:0]       rs1_data,
	output logic [rv_core_pkg::xlen-1:0]       rs2_data
);

	import rv_core_pkg::*;

	// x0 has no storage
	logic [xlen-1:0] regs [1:n_regs-1];

	assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
	assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

	always_ff @(posedge clk) begin
		if (rd_we && (rd_idx != '0)) begin
			regs[rd_idx] <= wb_data;
		end
	end

endmodule

`default_nettype wire

//--- verilog/exec_unit.sv
// execute stage: ALU, branch compare, jump target, word memory access and writeback select
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
	input  logic [rv_core_pkg::xlen-1:0]      pc,
	input  logic [rv_core_pkg::xlen-1:0]      rs1_data,
	input  logic [rv_core_pkg::xlen-1:0]      rs2_data,
	input  logic [rv_core_pkg::xlen-1:0]      imm,
	input  logic [rv_core_pkg::alu_op_w-1:0]  alu_op,
	input  logic                              alu_src_imm,
	input  logic [rv_core_pkg::wb_sel_w-1:0]  wb_sel,
	input  logic                              is_branch,
	input  logic                              branch_ne,
	input  logic                              is_jal,
	input  logic [rv_core_pkg::xlen-1:0]      dmem_rdata,
	output logic [rv_core_pkg::xlen-1:0]      wb_data,
	output logic                              redirect,
	output logic [rv_core_pkg::xlen-1:0]      redirect_target,
	output logic [rv_core_pkg::xlen-1:0]      dmem_addr,
	output logic [rv_core_pkg::xlen-1:0]      dmem_wdata
);

	import rv_core_pkg::*;

	logic [xlen-1:0] op_b;
	logic [xlen-1:0] alu_res;
	logic [xlen-1:0] link;
	logic            rs_eq;

	assign op_b = alu_src_imm ? imm : rs2_data;

	always_comb begin
		case (alu_op)
			alu_sub: alu_res = rs1_data - op_b;
			alu_and: alu_res = rs1_data & op_b;
			alu_or:  alu_res = rs1_data | op_b;
			alu_xor: alu_res = rs1_data ^ op_b;
			default: alu_res = rs1_data + op_b;
		endcase
	end

	// bne inverts the equality result
	assign rs_eq           = (rs1_data == rs2_data);
	assign redirect        = is_jal | (is_branch & (rs_eq ^ branch_ne));
	assign redirect_target = pc + imm;
	assign link            = pc + xlen'(4);

	// loads and stores decode as rs1 + imm on the adder
	assign dmem_addr  = alu_res;
	assign dmem_wdata = rs2_data;

	always_comb begin
		case (wb_sel)
			wb_mem:  wb_data = dmem_rdata;
			wb_link: wb_data = link;
			default: wb_data = alu_res;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
// single-cycle RV32I core top, joins PC, decode, register file and execute to the memory ports
`timescale 1ns/1ns
`default_nettype none

module rv_core (
	input  logic                          clk,
	input  logic                          rst_n,
	output logic [rv_core_pkg::xlen-1:0]  imem_addr,
	input  logic [rv_core_pkg::xlen-1:0]  imem_data,
	output logic [rv_core_pkg::xlen-1:0]  dmem_addr,
	output logic [rv_core_pkg::xlen-1:0]  dmem_wdata,
	input  logic [rv_core_pkg::xlen-1:0]  dmem_rdata,
	output logic                          dmem_we
);

	import rv_core_pkg::*;

	logic [xlen-1:0]      pc;
	logic                 redirect;
	logic [xlen-1:0]      redirect_target;
	logic [reg_idx_w-1:0] rs1_idx;
	logic [reg_idx_w-1:0] rs2_idx;
	logic [reg_idx_w-1:0] rd_idx;
	logic                 rd_we;
	logic [xlen-1:0]      imm;
	logic [alu_op_w-1:0]  alu_op;
	logic                 alu_src_imm;
	logic [wb_sel_w-1:0]  wb_sel;
	logic                 is_branch;
	logic                 branch_ne;
	logic                 is_jal;
	logic [xlen-1:0]      rs1_data;
	logic [xlen-1:0]      rs2_data;
	logic [xlen-1:0]      wb_data;

	// fetch address is the PC itself
	assign imem_addr = pc;

	pc_unit u_pc_unit (
		.clk             (clk),
		.rst_n           (rst_n),
		.redirect        (redirect),
		.redirect_target (redirect_target),
		.pc              (pc)
	);

	inst_decoder u_inst_decoder (
		.inst        (imem_data),
		.rst_n       (rst_n),
		.rs1_idx     (rs1_idx),
		.rs2_idx     (rs2_idx),
		.rd_idx      (rd_idx),
		.rd_we       (rd_we),
		.imm         (imm),
		.alu_op      (alu_op),
		.alu_src_imm (alu_src_imm),
		.wb_sel      (wb_sel),
		.is_branch   (is_branch),
		.branch_ne   (branch_ne),
		.is_jal      (is_jal),
		.mem_we      (dmem_we)
	);

	gpr_file u_gpr_file (
		.clk      (clk),
		.rs1_idx  (rs1_idx),
		.rs2_idx  (rs2_idx),
		.rd_idx   (rd_idx),
		.rd_we    (rd_we),
		.wb_data  (wb_data),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	exec_unit u_exec_unit (
		.pc              (pc),
		.rs1_data        (rs1_data),
		.rs2_data        (rs2_data),
		.imm             (imm),
		.alu_op          (alu_op),
		.alu_src_imm     (alu_src_imm),
		.wb_sel          (wb_sel),
		.is_branch       (is_branch),
		.branch_ne       (branch_ne),
		.is_jal          (is_jal),
		.dmem_rdata      (dmem_rdata),
		.wb_data         (wb_data),
		.redirect        (redirect),
		.redirect_target (redirect_target),
		.dmem_addr       (dmem_addr),
		.dmem_wdata      (dmem_wdata)
	);

endmodule

`default_nettype wire

//--- test/rv_core_sva.sv
// reset and fetch assertions, bound into every rv_core instance
`timescale 1ns/1ns
`default_nettype none

module rv_core_sva (
	input logic                          clk,
	input logic                          rst_n,
	input logic [rv_core_pkg::xlen-1:0]  imem_addr,
	input logic                          dmem_we,
	input logic                          is_branch,
	input logic                          is_jal
);

	import rv_core_pkg::*;

	a_no_write_in_reset: assert property (@(posedge clk) !rst_n |-> !dmem_we)
		else $error("dmem_we high while rst_n is low");

	a_fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		imem_addr[1:0] == 2'b00)
		else $error("imem_addr not word aligned");

	a_first_fetch: assert property (@(posedge clk) $rose(rst_n) |-> imem_addr == pc_reset)
		else $error("first fetch after reset not at the reset PC");

	// straight-line code steps by one word
	a_sequential: assert property (@(posedge clk) disable iff (!rst_n)
		(rst_n && !is_branch && !is_jal) |=> imem_addr == $past(imem_addr) + xlen'(4))
		else $error("PC did not advance by four");

endmodule

bind rv_core rv_core_sva u_sva (
	.clk       (clk),
	.rst_n     (rst_n),
	.imem_addr (imem_addr),
	.dmem_we   (dmem_we),
	.is_branch (is_branch),
	.is_jal    (is_jal)
);

`default_nettype wire

//--- test/rv_core_tb.sv
// directed testbench for the single-cycle core, with memory models and an instruction encoder
`timescale 1ns/1ns
`default_nettype none

module rv_core_tb;

	import rv_core_pkg::*;

	logic        clk;
	logic        rst_n;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic [31:0] dmem_rdata;
	logic        dmem_we;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];
	logic [31:0] exp_mem [0:255];
	int          prog_len;
	int          errors;

	rv_core UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_rdata (dmem_rdata),
		.dmem_we    (dmem_we)
	);

	always #5 clk = ~clk;

	// both memories answer within the cycle
	assign imem_data  = imem[imem_addr[9:2]];
	assign dmem_rdata = dmem[dmem_addr[9:2]];

	always @(posedge clk) begin
		if (dmem_we) begin
			dmem[dmem_addr[9:2]] <= dmem_wdata;
		end
	end

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	// sw only, funct3 010
	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, op_lui};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
	endfunction

	task automatic emit(input logic [31:0] word);
		imem[prog_len] = word;
		prog_len++;
	endtask

	// lui + addi, upper part rounded for the sign of the low twelve bits
	task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
		logic [31:0] hi;
		hi = v + 32'h800;
		emit(u_type(hi[31:12], rd));
		emit(i_type(v[11:0], rd, f3_add, rd, op_imm));
	endtask

	task automatic check_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic start_test;
		int i;
		@(negedge clk);
		rst_n = 1'b0;
		for (i = 0; i < 256; i++) begin
			imem[i] = 32'h0;
			dmem[i] = {16'hc3a5, i[7:0], ~i[7:0]};
			exp_mem[i] = dmem[i];
		end
		prog_len = 0;
	endtask

	task automatic run_program;
		logic [31:0] loop_addr;
		int          cycles;
		loop_addr = prog_len * 4;
		emit(j_type(21'd0, 5'd0));
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		cycles = 0;
		while (imem_addr !== loop_addr && cycles < 500) begin
			@(negedge clk);
			cycles++;
		end
		if (imem_addr !== loop_addr) begin
			errors++;
			$display("program did not reach its final loop at %h in time", loop_addr);
		end
	endtask

	task automatic compare_memory;
		int i;
		for (i = 0; i < 256; i++) begin
			check_word($sformatf("dmem[0x%h]", i * 4), exp_mem[i], dmem[i]);
		end
	endtask

	task automatic alu_step(input logic [31:0] inst, input logic [11:0] off,
		input logic [31:0] expected);
		emit(inst);
		emit(s_type(off, 5'd3, 5'd0));
		exp_mem[off[9:2]] = expected;
	endtask

	task automatic reset_hold;
		start_test();
		emit(i_type(12'h05a, 5'd0, f3_add, 5'd1, op_imm));
		emit(s_type(12'h100, 5'd1, 5'd0));
		emit(s_type(12'h104, 5'd1, 5'd0));
		repeat (4) begin
			@(negedge clk);
			check_word("imem_addr", 32'h0, imem_addr);
			check_word("dmem_we", 32'h0, {31'b0, dmem_we});
		end
		rst_n = 1'b1;
		#1;
		check_word("imem_addr", 32'h0, imem_addr);
		check_word("dmem_we", 32'h0, {31'b0, dmem_we});
		// back into reset before the first store can run
		@(negedge clk);
		rst_n = 1'b0;
		#1;
		// the store at word one is decoded but held off
		check_word("imem_addr", 32'h4, imem_addr);
		check_word("dmem_we", 32'h0, {31'b0, dmem_we});
		repeat (2) @(negedge clk);
		compare_memory();
	endtask

	task automatic alu_ops;
		logic [31:0] a;
		logic [31:0] b;
		logic [11:0] imm;
		start_test();
		a = $urandom;
		b = $urandom;
		imm = 12'($urandom);
		load_const(5'd1, a);
		load_const(5'd2, b);
		alu_step(r_type(7'h00, 5'd2, 5'd1, f3_add, 5'd3), 12'h100, a + b);
		alu_step(r_type(7'h20, 5'd2, 5'd1, f3_add, 5'd3), 12'h104, a - b);
		alu_step(r_type(7'h00, 5'd2, 5'd1, f3_and, 5'd3), 12'h108, a & b);
		alu_step(r_type(7'h00, 5'd2, 5'd1, f3_or, 5'd3), 12'h10c, a | b);
		alu_step(r_type(7'h00, 5'd2, 5'd1, f3_xor, 5'd3), 12'h110, a ^ b);
		alu_step(i_type(imm, 5'd1, f3_and, 5'd3, op_imm), 12'h114, a & sext12(imm));
		alu_step(i_type(imm, 5'd1, f3_or, 5'd3, op_imm), 12'h118, a | sext12(imm));
		alu_step(i_type(imm, 5'd1, f3_xor, 5'd3, op_imm), 12'h11c, a ^ sext12(imm));
		run_program();
		compare_memory();
	endtask

	task automatic load_store;
		logic [11:0] ld_off [0:1];
		logic [11:0] st_off [0:1];
		logic [31:0] word;
		logic [31:0] ld_addr;
		logic [31:0] st_addr;
		logic [11:0] imm;
		int          k;
		start_test();
		ld_off[0] = 12'h008;
		ld_off[1] = 12'hff8;
		st_off[0] = 12'h00c;
		st_off[1] = 12'hffc;
		load_const(5'd6, 32'h200);
		load_const(5'd7, 32'h300);
		for (k = 0; k < 2; k++) begin
			word = $urandom;
			imm = 12'($urandom);
			ld_addr = 32'h200 + sext12(ld_off[k]);
			st_addr = 32'h300 + sext12(st_off[k]);
			dmem[ld_addr[9:2]] = word;
			exp_mem[ld_addr[9:2]] = word;
			exp_mem[st_addr[9:2]] = word + sext12(imm);
			emit(i_type(ld_off[k], 5'd6, 3'b010, 5'd5, op_load));
			emit(i_type(imm, 5'd5, f3_add, 5'd5, op_imm));
			emit(s_type(st_off[k], 5'd5, 5'd7));
		end
		run_program();
		compare_memory();
	endtask

	// marker store sits on the path a taken branch skips
	task automatic branch_and_mark(input logic [31:0] inst, input logic [11:0] addr,
		input logic taken, input logic [31:0] marker);
		emit(inst);
		emit(s_type(addr, 5'd10, 5'd0));
		if (!taken) begin
			exp_mem[addr[9:2]] = marker;
		end
	endtask

	task automatic branch_paths;
		logic [31:0] r;
		logic [31:0] marker;
		start_test();
		r = $urandom;
		marker = $urandom;
		load_const(5'd1, r);
		load_const(5'd2, r);
		load_const(5'd3, r ^ 32'h10);
		load_const(5'd10, marker);
		branch_and_mark(b_type(13'd8, 5'd2, 5'd1, f3_beq), 12'h380, 1'b1, marker);
		branch_and_mark(b_type(13'd8, 5'd3, 5'd1, f3_beq), 12'h384, 1'b0, marker);
		branch_and_mark(b_type(13'd8, 5'd3, 5'd1, f3_bne), 12'h388, 1'b1, marker);
		branch_and_mark(b_type(13'd8, 5'd2, 5'd1, f3_bne), 12'h38c, 1'b0, marker);
		run_program();
		compare_memory();
	endtask

	task automatic jump_link;
		logic [31:0] jal_addr;
		start_test();
		load_const(5'd5, 32'hffff_ffff);
		jal_addr = prog_len * 4;
		emit(j_type(21'd8, 5'd5));
		emit(s_type(12'h3a0, 5'd0, 5'd0));
		emit(s_type(12'h3a4, 5'd5, 5'd0));
		exp_mem[12'h3a4 >> 2] = jal_addr + 4;
		run_program();
		compare_memory();
	endtask

	task automatic zero_reg;
		start_test();
		emit(i_type(12'h123, 5'd0, f3_add, 5'd0, op_imm));
		emit(u_type(20'habcde, 5'd0));
		emit(i_type(12'h100, 5'd0, 3'b010, 5'd0, op_load));
		emit(s_type(12'h3b0, 5'd0, 5'd0));
		exp_mem[12'h3b0 >> 2] = 32'h0;
		run_program();
		compare_memory();
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		errors = 0;
		prog_len = 0;
		void'($urandom(32'h8d41));
		reset_hold();
		alu_ops();
		load_store();
		branch_paths();
		jump_link();
		zero_reg();
		$display("%0d errors", errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- rv_core.f
verilog/rv_core_pkg.sv
verilog/pc_unit.sv
verilog/inst_decoder.sv
verilog/gpr_file.sv
verilog/exec_unit.sv
verilog/rv_core.sv
test/rv_core_sva.sv
test/rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - verilog/rv_core_pkg.sv
  - verilog/pc_unit.sv
  - verilog/inst_decoder.sv
  - verilog/gpr_file.sv
  - verilog/exec_unit.sv
  - verilog/rv_core.sv
  - target: test
    files:
      - test/rv_core_sva.sv
      - test/rv_core_tb.sv
